/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* cache.f */
design/cache_pkg.sv
design/cache_front_end.sv
design/cache_way.sv
design/cache_way_select.sv
design/cache_wtbuf.sv
design/cache_back_end.sv
design/cache_control.sv
design/cache_top.sv
tb/cache_tb.sv

/* design/cache_back_end.sv */
`timescale 1ns/10ps

module cache_back_end
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   // Write-through buffer head
   input  logic              wtb_valid,
   input  logic [addr_w-1:0] head_addr,
   input  logic [data_w-1:0] head_wdata,
   input  logic [nbytes-1:0] head_wstrb,
   output logic              wtb_pop,
   // Line fill from the selector
   input  logic              fill_req,
   input  logic [addr_w-1:0] fill_addr,
   output logic              fill_ack,
   output logic [data_w-1:0] fill_rdata,
   // Memory port
   output logic              be_req,
   output logic [addr_w-1:0] be_addr,
   output logic [data_w-1:0] be_wdata,
   output logic [nbytes-1:0] be_wstrb,
   input  logic [data_w-1:0] be_rdata,
   input  logic              be_ack
);

   logic busy;       // Port owned until be_ack
   logic is_fill;    // Current transfer is a read

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         is_fill <= 1'b0;
      end else if (!busy) begin
         busy    <= wtb_valid | fill_req;
         is_fill <= ~wtb_valid;                   // Drain wins over fill
      end else if (be_ack) begin
         busy <= 1'b0;
      end
   end

   // Request fields, frozen while busy
   always_ff @(posedge clk) begin
      if (!busy) begin
         if (wtb_valid) begin
            be_addr  <= head_addr;
            be_wdata <= head_wdata;
            be_wstrb <= head_wstrb;
         end else begin
            be_addr  <= fill_addr;
            be_wdata <= head_wdata;               // Don't care on reads
            be_wstrb <= '0;
         end
      end
   end

   assign be_req = busy;

   // Completion goes to whichever side started it
   assign wtb_pop    = busy & be_ack & ~is_fill;
   assign fill_ack   = busy & be_ack & is_fill;
   assign fill_rdata = be_rdata;

endmodule

/* design/cache_control.sv */
`timescale 1ns/10ps

module cache_control
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   ctrl_req,
   input  logic [ctrl_addr_w-1:0] ctrl_addr,
   input  logic                   ctrl_write,
   input  logic                   wtbuf_empty,
   input  logic                   wtbuf_full,
   input  logic                   read_hit,
   input  logic                   read_miss,
   input  logic                   write_hit,
   input  logic                   write_miss,
   output logic                   ctrl_ack,
   output logic [data_w-1:0]      ctrl_rdata,
   output logic                   invalidate
);

   logic [cnt_w-1:0] cnt [4];   // Read hit, read miss, write hit, write miss
   logic [3:0]       events;
   logic             cnt_clear;
   logic [data_w-1:0] reg_val;

   assign events    = {write_miss, write_hit, read_miss, read_hit};
   assign cnt_clear = ctrl_req & ctrl_write & (ctrl_addr == reg_cnt_reset);

   always_ff @(posedge clk) begin
      if (!rst_n || cnt_clear) begin
         for (int i = 0; i < 4; i++) cnt[i] <= '0;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (events[i] && !(&cnt[i])) cnt[i] <= cnt[i] + 1'b1;  // Saturate
         end
      end
   end

   // Register read mux
   always_comb begin
      case (ctrl_addr)
         reg_wtb_empty:  reg_val = data_w'(wtbuf_empty);
         reg_wtb_full:   reg_val = data_w'(wtbuf_full);
         reg_read_hit:   reg_val = data_w'(cnt[0]);
         reg_read_miss:  reg_val = data_w'(cnt[1]);
         reg_write_hit:  reg_val = data_w'(cnt[2]);
         reg_write_miss: reg_val = data_w'(cnt[3]);
         default:        reg_val = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
      end else begin
         ctrl_ack   <= ctrl_req;                 // Fixed one cycle latency
         invalidate <= ctrl_req & ctrl_write & (ctrl_addr == reg_invalidate);
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl_req) ctrl_rdata <= ctrl_write ? '0 : reg_val;
   end

endmodule

/* design/cache_front_end.sv */
`timescale 1ns/10ps

module cache_front_end
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Host side
   input  logic                   req,
   input  logic [addr_w:0]        addr,
   input  logic [data_w-1:0]      wdata,
   input  logic [nbytes-1:0]      wstrb,
   output logic                   ack,
   output logic [data_w-1:0]      rdata,
   // Memory path
   output logic                   data_req,
   output logic [addr_w-1:0]      data_addr_reg,
   output logic [data_w-1:0]      data_wdata_reg,
   output logic [nbytes-1:0]      data_wstrb_reg,
   input  logic                   data_ack,
   input  logic [data_w-1:0]      data_rdata,
   // Controller path
   output logic                   ctrl_req,
   output logic [ctrl_addr_w-1:0] ctrl_addr,
   output logic                   ctrl_write,
   input  logic                   ctrl_ack,
   input  logic [data_w-1:0]      ctrl_rdata
);

   logic ctrl_pend;  // Controller answers next cycle
   logic accept;     // Free to take a new request

   // Idle, or the current one finishes now
   assign ack    = (data_req & data_ack) | (ctrl_pend & ctrl_ack);
   assign accept = ~(data_req | ctrl_pend) | ack;

   // Controller sees the request in the sampling cycle and acks one later
   assign ctrl_req   = req & accept & addr[addr_w];
   assign ctrl_addr  = addr[ctrl_addr_w-1:0];
   assign ctrl_write = |wstrb;            // Only place the strobe is decoded

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         data_req  <= 1'b0;
         ctrl_pend <= 1'b0;
      end else if (accept) begin
         data_req  <= req & ~addr[addr_w];
         ctrl_pend <= req & addr[addr_w];
      end
   end

   // Request payload, held while the memory path works on it
   always_ff @(posedge clk) begin
      if (accept && req) begin
         data_addr_reg  <= addr[addr_w-1:0];
         data_wdata_reg <= wdata;
         data_wstrb_reg <= wstrb;
      end
   end

   assign rdata = ctrl_pend ? ctrl_rdata : data_rdata;   // Path that owns the ack

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

   // Word address space of the cache, top host bit selects the controller
   localparam int addr_w = 12;
   localparam int data_w = 32;
   localparam int nbytes = 4;       // Strobe width

   // Organisation
   localparam int nways    = 2;     // One LRU bit per set assumes two ways
   localparam int nlines_w = 4;
   localparam int nsets    = 2 ** nlines_w;
   localparam int tag_w    = addr_w - nlines_w;

   // Write-through buffer
   localparam int wtbuf_depth_w = 2;
   localparam int wtbuf_depth   = 2 ** wtbuf_depth_w;

   // Controller register map
   localparam int ctrl_addr_w = 3;
   localparam logic [ctrl_addr_w-1:0] reg_wtb_empty  = 3'd0;
   localparam logic [ctrl_addr_w-1:0] reg_wtb_full   = 3'd1;
   localparam logic [ctrl_addr_w-1:0] reg_read_hit   = 3'd2;
   localparam logic [ctrl_addr_w-1:0] reg_read_miss  = 3'd3;
   localparam logic [ctrl_addr_w-1:0] reg_write_hit  = 3'd4;
   localparam logic [ctrl_addr_w-1:0] reg_write_miss = 3'd5;
   localparam logic [ctrl_addr_w-1:0] reg_invalidate = 3'd6; // Write only
   localparam logic [ctrl_addr_w-1:0] reg_cnt_reset  = 3'd7; // Write only

   localparam int cnt_w = 16;       // Hit/miss counters, saturating

endpackage

/* design/cache_top.sv */
`timescale 1ns/10ps

module cache_top
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   // Host port
   input  logic              req,
   input  logic [addr_w:0]   addr,        // MSB selects the controller
   input  logic [data_w-1:0] wdata,
   input  logic [nbytes-1:0] wstrb,
   output logic              ack,
   output logic [data_w-1:0] rdata,
   // Memory port
   output logic              be_req,
   output logic [addr_w-1:0] be_addr,
   output logic [data_w-1:0] be_wdata,
   output logic [nbytes-1:0] be_wstrb,
   input  logic [data_w-1:0] be_rdata,
   input  logic              be_ack,
   // Hierarchy chain
   input  logic              invalidate_in,
   output logic              invalidate_out,
   input  logic              wtb_empty_in,
   output logic              wtb_empty_out
);

   logic                   data_req, data_ack;
   logic [addr_w-1:0]      data_addr_reg;
   logic [data_w-1:0]      data_wdata_reg, data_rdata;
   logic [nbytes-1:0]      data_wstrb_reg;
   logic                   ctrl_req, ctrl_ack, ctrl_write, ctrl_invalidate;
   logic [ctrl_addr_w-1:0] ctrl_addr;
   logic [data_w-1:0]      ctrl_rdata;
   logic [nways-1:0]       hits, fill_en, wr_en;
   logic [data_w-1:0]      way_rdata [nways];
   logic                   wtb_push, wtb_pop, wtb_valid, wtbuf_full, wtbuf_empty;
   logic [addr_w-1:0]      head_addr;
   logic [data_w-1:0]      head_wdata;
   logic [nbytes-1:0]      head_wstrb;
   logic                   fill_req, fill_ack;
   logic [data_w-1:0]      fill_rdata;
   logic                   read_hit, read_miss, write_hit, write_miss;

   // Chain gates
   assign invalidate_out = ctrl_invalidate | invalidate_in;
   assign wtb_empty_out  = wtbuf_empty & wtb_empty_in;

   cache_front_end u_front_end (
      .clk, .rst_n, .req, .addr, .wdata, .wstrb, .ack, .rdata,
      .data_req, .data_addr_reg, .data_wdata_reg, .data_wstrb_reg, .data_ack, .data_rdata,
      .ctrl_req, .ctrl_addr, .ctrl_write, .ctrl_ack, .ctrl_rdata
   );

   for (genvar i = 0; i < nways; i++) begin : g_way
      cache_way u_way (
         .clk, .rst_n,
         .invalidate  (invalidate_out),       // Local and chained flush
         .lookup_addr (data_addr_reg),
         .fill_en     (fill_en[i]),
         .fill_rdata  (fill_rdata),
         .wr_en       (wr_en[i]),
         .wdata       (data_wdata_reg),
         .wstrb       (data_wstrb_reg),
         .hit         (hits[i]),
         .rdata       (way_rdata[i])
      );
   end

   cache_way_select u_way_select (
      .clk, .rst_n, .data_req, .data_addr_reg, .data_wstrb_reg, .hits, .way_rdata,
      .wtbuf_full, .wtbuf_empty, .fill_ack, .fill_rdata, .data_ack, .data_rdata,
      .fill_en, .wr_en, .wtb_push, .fill_req,
      .read_hit, .read_miss, .write_hit, .write_miss
   );

   cache_wtbuf u_wtbuf (
      .clk, .rst_n, .wtb_push,
      .push_addr  (data_addr_reg),
      .push_wdata (data_wdata_reg),
      .push_wstrb (data_wstrb_reg),
      .wtb_pop, .wtb_valid, .head_addr, .head_wdata, .head_wstrb, .wtbuf_full, .wtbuf_empty
   );

   cache_back_end u_back_end (
      .clk, .rst_n, .wtb_valid, .head_addr, .head_wdata, .head_wstrb, .wtb_pop,
      .fill_req,
      .fill_addr (data_addr_reg),             // Held by the front end during the miss
      .fill_ack, .fill_rdata,
      .be_req, .be_addr, .be_wdata, .be_wstrb, .be_rdata, .be_ack
   );

   cache_control u_control (
      .clk, .rst_n, .ctrl_req, .ctrl_addr, .ctrl_write, .wtbuf_empty, .wtbuf_full,
      .read_hit, .read_miss, .write_hit, .write_miss, .ctrl_ack, .ctrl_rdata,
      .invalidate (ctrl_invalidate)
   );

endmodule

/* design/cache_way.sv */
`timescale 1ns/10ps

module cache_way
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              invalidate,
   input  logic [addr_w-1:0] lookup_addr,
   input  logic              fill_en,       // Allocate line from back end
   input  logic [data_w-1:0] fill_rdata,
   input  logic              wr_en,         // Write hit in this way
   input  logic [data_w-1:0] wdata,
   input  logic [nbytes-1:0] wstrb,
   output logic              hit,
   output logic [data_w-1:0] rdata
);

   logic [nsets-1:0]  valid;
   logic [tag_w-1:0]  tag_mem  [nsets];
   logic [data_w-1:0] data_mem [nsets];

   logic [nlines_w-1:0] idx;
   logic [tag_w-1:0]    tag;

   assign idx = lookup_addr[nlines_w-1:0];
   assign tag = lookup_addr[addr_w-1:nlines_w];

   // Parallel lookup, one per way
   assign hit   = valid[idx] && (tag_mem[idx] == tag);
   assign rdata = data_mem[idx];

   always_ff @(posedge clk) begin
      if (!rst_n || invalidate) begin
         valid <= '0;                    // Flush all sets at once
      end else if (fill_en) begin
         valid[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= fill_rdata;    // Whole word from memory
      end else if (wr_en) begin
         for (int b = 0; b < nbytes; b++) begin
            if (wstrb[b]) data_mem[idx][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

endmodule

/* design/cache_way_select.sv */
`timescale 1ns/10ps

module cache_way_select
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              data_req,
   input  logic [addr_w-1:0] data_addr_reg,
   input  logic [nbytes-1:0] data_wstrb_reg,
   input  logic [nways-1:0]  hits,
   input  logic [data_w-1:0] way_rdata [nways],
   input  logic              wtbuf_full,
   input  logic              wtbuf_empty,
   input  logic              fill_ack,
   input  logic [data_w-1:0] fill_rdata,
   output logic              data_ack,
   output logic [data_w-1:0] data_rdata,
   output logic [nways-1:0]  fill_en,
   output logic [nways-1:0]  wr_en,
   output logic              wtb_push,
   output logic              fill_req,
   output logic              read_hit,
   output logic              read_miss,
   output logic              write_hit,
   output logic              write_miss
);

   logic [nsets-1:0]    lru;        // Per set, the way to replace next
   logic [nlines_w-1:0] idx;
   logic                is_write;
   logic                hit;
   logic                hit_way;
   logic [data_w-1:0]   hit_word;
   logic                lookup_ack;

   assign idx      = data_addr_reg[nlines_w-1:0];
   assign is_write = |data_wstrb_reg;
   assign hit      = |hits;

   // Hit way index and its word
   always_comb begin
      hit_way  = 1'b0;
      hit_word = '0;
      for (int i = 0; i < nways; i++) begin
         if (hits[i]) begin
            hit_way  = 1'(i);
            hit_word = way_rdata[i];
         end
      end
   end

   // Writes go straight to the buffer, stalled only when it is full
   assign wtb_push   = data_req & is_write & ~fill_req & ~wtbuf_full;
   assign lookup_ack = data_req & ~is_write & hit & ~fill_req;
   assign data_ack   = wtb_push | lookup_ack | (fill_req & fill_ack);
   assign data_rdata = fill_req ? fill_rdata : hit_word;

   always_comb begin
      for (int i = 0; i < nways; i++) begin
         wr_en[i]   = wtb_push & hits[i];
         fill_en[i] = fill_req & fill_ack & (lru[idx] == 1'(i));  // Victim way
      end
   end

   // Miss sequence: wait for the buffer to drain, then fill
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fill_req <= 1'b0;
      end else if (fill_req) begin
         fill_req <= ~fill_ack;
      end else begin
         fill_req <= data_req & ~is_write & ~hit & wtbuf_empty;  // Read after write
      end
   end

   // Access marks its way MRU; write misses leave LRU alone
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lru <= '0;
      end else if (fill_req && fill_ack) begin
         lru[idx] <= ~lru[idx];
      end else if (lookup_ack || (wtb_push && hit)) begin
         lru[idx] <= ~hit_way;
      end
   end

   // One event per access, on ack
   assign read_hit   = lookup_ack;
   assign read_miss  = fill_req & fill_ack;
   assign write_hit  = wtb_push & hit;
   assign write_miss = wtb_push & ~hit;

endmodule

/* design/cache_wtbuf.sv */
`timescale 1ns/10ps

module cache_wtbuf
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wtb_push,
   input  logic [addr_w-1:0] push_addr,
   input  logic [data_w-1:0] push_wdata,
   input  logic [nbytes-1:0] push_wstrb,
   input  logic              wtb_pop,
   output logic              wtb_valid,
   output logic [addr_w-1:0] head_addr,
   output logic [data_w-1:0] head_wdata,
   output logic [nbytes-1:0] head_wstrb,
   output logic              wtbuf_full,
   output logic              wtbuf_empty
);

   logic [addr_w-1:0] addr_mem  [wtbuf_depth];
   logic [data_w-1:0] wdata_mem [wtbuf_depth];
   logic [nbytes-1:0] wstrb_mem [wtbuf_depth];

   logic [wtbuf_depth_w-1:0] wr_ptr;
   logic [wtbuf_depth_w-1:0] rd_ptr;
   logic [wtbuf_depth_w:0]   count;    // One extra bit for full
   logic                     do_push;
   logic                     do_pop;

   assign wtbuf_full  = (count == (wtbuf_depth_w+1)'(wtbuf_depth));
   assign wtbuf_empty = (count == '0);
   assign wtb_valid   = ~wtbuf_empty;

   assign do_push = wtb_push & ~wtbuf_full;
   assign do_pop  = wtb_pop & ~wtbuf_empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;     // Pointers wrap naturally
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         count <= count + do_push - do_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         addr_mem[wr_ptr]  <= push_addr;
         wdata_mem[wr_ptr] <= push_wdata;
         wstrb_mem[wr_ptr] <= push_wstrb;
      end
   end

   // Head entry offered to the back end
   assign head_addr  = addr_mem[rd_ptr];
   assign head_wdata = wdata_mem[rd_ptr];
   assign head_wstrb = wstrb_mem[rd_ptr];

endmodule

/* tb/cache_tb.sv */
`timescale 1ns/10ps

module cache_tb
   import cache_pkg::*;
();

   typedef enum logic [2:0] {
      op_rd, op_wr, op_crd, op_cwr, op_mem_chk, op_empty_chain, op_inv_in, op_slow
   } op_e;

   typedef struct packed {
      op_e               op;
      logic [addr_w:0]   addr;     // Register index for controller rows
      logic [data_w-1:0] wdata;
      logic [nbytes-1:0] wstrb;
      logic [data_w-1:0] exp;      // Controller rows only since memory reads use the shadow
      logic              one;      // Ack due one cycle after sampling
   } row_t;

   localparam int n_rows        = 45;
   localparam int ack_timeout   = 100;
   localparam int drain_timeout = 300;

   logic              clk, rst_n;
   logic              req, ack;
   logic [addr_w:0]   addr;
   logic [data_w-1:0] wdata, rdata;
   logic [nbytes-1:0] wstrb;
   logic              be_req, be_ack;
   logic [addr_w-1:0] be_addr;
   logic [data_w-1:0] be_wdata, be_rdata;
   logic [nbytes-1:0] be_wstrb;
   logic              invalidate_in, invalidate_out, wtb_empty_in, wtb_empty_out;

   logic [data_w-1:0] mem    [2**addr_w];   // Back-end memory
   logic [data_w-1:0] shadow [2**addr_w];   // Predicted contents
   bit                written [2**addr_w];
   integer            seed = 91;
   bit                slow;                 // Long fixed be_ack delay
   int                errors;
   int                checks;

   // Set 5 takes tags 0, 1 and 2 to force LRU eviction
   row_t rows [n_rows] = '{
      '{op_rd,  13'h005, 32'h0, 4'h0, 32'd0, 1'b0},          // Cold miss into way 0
      '{op_rd,  13'h005, 32'h0, 4'h0, 32'd0, 1'b1},
      '{op_wr,  13'h005, 32'h11223344, 4'h5, 32'd0, 1'b1},   // Partial write hit
      '{op_rd,  13'h005, 32'h0, 4'h0, 32'd0, 1'b1},
      '{op_rd,  13'h015, 32'h0, 4'h0, 32'd0, 1'b0},          // Way 1
      '{op_rd,  13'h005, 32'h0, 4'h0, 32'd0, 1'b1},          // Way 0 now MRU
      '{op_rd,  13'h025, 32'h0, 4'h0, 32'd0, 1'b0},          // Evicts 015
      '{op_rd,  13'h015, 32'h0, 4'h0, 32'd0, 1'b0},          // Evicts 005
      '{op_rd,  13'h025, 32'h0, 4'h0, 32'd0, 1'b1},
      '{op_wr,  13'h005, 32'hab000000, 4'h8, 32'd0, 1'b1},   // Write miss without allocate
      '{op_rd,  13'h005, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_wr,  13'h025, 32'h0000beef, 4'h3, 32'd0, 1'b1},
      '{op_rd,  13'h025, 32'h0, 4'h0, 32'd0, 1'b1},
      '{op_crd, 13'(reg_read_hit),   32'h0, 4'h0, 32'd5, 1'b1},
      '{op_crd, 13'(reg_read_miss),  32'h0, 4'h0, 32'd5, 1'b1},
      '{op_crd, 13'(reg_write_hit),  32'h0, 4'h0, 32'd2, 1'b1},
      '{op_crd, 13'(reg_write_miss), 32'h0, 4'h0, 32'd1, 1'b1},
      '{op_mem_chk,     13'h0, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_empty_chain, 13'h0, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_cwr, 13'(reg_invalidate), 32'h1, 4'hf, 32'd1, 1'b1},
      '{op_rd,  13'h025, 32'h0, 4'h0, 32'd0, 1'b0},          // Miss after flush
      '{op_rd,  13'h025, 32'h0, 4'h0, 32'd0, 1'b1},
      '{op_inv_in,      13'h0, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_rd,  13'h025, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_crd, 13'(reg_read_miss),  32'h0, 4'h0, 32'd7, 1'b1},
      '{op_crd, 13'(reg_read_hit),   32'h0, 4'h0, 32'd6, 1'b1},
      '{op_cwr, 13'(reg_cnt_reset),  32'h1, 4'hf, 32'd0, 1'b1},
      '{op_crd, 13'(reg_read_miss),  32'h0, 4'h0, 32'd0, 1'b1},
      '{op_slow, 13'h0, 32'h1, 4'h0, 32'd0, 1'b0},
      '{op_wr,  13'h100, 32'ha1a2a3a4, 4'hf, 32'd0, 1'b0},   // Burst against slow memory
      '{op_wr,  13'h101, 32'hb1b2b3b4, 4'h3, 32'd0, 1'b0},
      '{op_wr,  13'h102, 32'hc1c2c3c4, 4'hc, 32'd0, 1'b0},
      '{op_wr,  13'h103, 32'hd1d2d3d4, 4'h6, 32'd0, 1'b0},
      '{op_wr,  13'h100, 32'he1e2e3e4, 4'h8, 32'd0, 1'b0},   // Same word again so order matters
      '{op_wr,  13'h104, 32'hf1f2f3f4, 4'h1, 32'd0, 1'b0},
      '{op_crd, 13'(reg_wtb_full),   32'h0, 4'h0, 32'd1, 1'b1},
      '{op_crd, 13'(reg_wtb_empty),  32'h0, 4'h0, 32'd0, 1'b1},
      '{op_slow, 13'h0, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_mem_chk,     13'h0, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_crd, 13'(reg_wtb_empty),  32'h0, 4'h0, 32'd1, 1'b1},
      '{op_crd, 13'(reg_write_miss), 32'h0, 4'h0, 32'd6, 1'b1},
      '{op_rd,  13'h103, 32'h0, 4'h0, 32'd0, 1'b0},
      '{op_rd,  13'h103, 32'h0, 4'h0, 32'd0, 1'b1},
      '{op_crd, 13'(reg_read_hit),   32'h0, 4'h0, 32'd1, 1'b1},
      '{op_crd, 13'(reg_read_miss),  32'h0, 4'h0, 32'd1, 1'b1}
   };

   cache_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [data_w-1:0] apply_strobes(input logic [data_w-1:0] old,
         input logic [data_w-1:0] wd, input logic [nbytes-1:0] ws);
      logic [data_w-1:0] word;
      word = old;
      for (int b = 0; b < nbytes; b++) begin
         if (ws[b]) word[8*b +: 8] = wd[8*b +: 8];
      end
      return word;
   endfunction

   function automatic logic [addr_w:0] ctrl_host_addr(input logic [addr_w:0] idx);
      return {1'b1, {(addr_w-ctrl_addr_w){1'b0}}, idx[ctrl_addr_w-1:0]};
   endfunction

   task automatic check(input string name, input logic [data_w-1:0] got,
         input logic [data_w-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // One request held high for its sampling cycle before the wait for ack
   task automatic host_access(input logic [addr_w:0] a, input logic [data_w-1:0] wd,
         input logic [nbytes-1:0] ws, output logic [data_w-1:0] rd, output int lat,
         output logic inv);
      @(posedge clk);
      #10;
      req   = 1'b1;
      addr  = a;
      wdata = wd;
      wstrb = ws;
      @(posedge clk);                  // Front end is idle and takes it here
      #10;
      req = 1'b0;
      rd  = '0;
      inv = 1'b0;
      lat = 0;
      do begin
         @(negedge clk);               // Mid cycle where all drives have settled
         lat++;
      end while (!ack && lat < ack_timeout);
      if (ack) begin
         rd  = rdata;
         inv = invalidate_out;
      end else begin
         errors++;
         $display("Timeout: no ack from the cache for host address %h", a);
      end
   endtask

   // Memory model with a random 0 to 4 cycle latency unless slow
   initial begin
      int wait_left;
      bit pending;
      be_ack    = 1'b0;
      be_rdata  = '0;
      pending   = 1'b0;
      wait_left = 0;
      forever begin
         @(posedge clk);
         #10;
         if (be_ack) begin
            be_ack = 1'b0;             // Port released at this edge
         end else if (be_req) begin
            if (!pending) begin
               pending   = 1'b1;
               wait_left = slow ? 8 : {$random(seed)} % 5;
            end
            if (wait_left == 0) begin
               if (be_wstrb != '0) mem[be_addr] = apply_strobes(mem[be_addr], be_wdata, be_wstrb);
               else be_rdata = mem[be_addr];
               be_ack  = 1'b1;
               pending = 1'b0;
            end else begin
               wait_left--;
            end
         end
      end
   end

   initial begin
      logic [data_w-1:0] rd;
      int                lat;
      logic              inv;
      row_t              r;
      req           = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      wtb_empty_in  = 1'b1;
      rst_n         = 1'b0;
      slow          = 1'b0;
      errors        = 0;
      checks        = 0;
      for (int i = 0; i < 2**addr_w; i++) begin
         mem[i]     = {4'hc, i[11:0], 4'h3, ~i[11:0]};   // Unique per address
         shadow[i]  = mem[i];
         written[i] = 1'b0;
      end
      repeat (3) @(posedge clk);
      #10;
      rst_n = 1'b1;

      for (int i = 0; i < n_rows; i++) begin
         r   = rows[i];
         lat = 0;
         case (r.op)
            op_rd: begin
               host_access(r.addr, '0, '0, rd, lat, inv);
               check($sformatf("rdata[%h]", r.addr), rd, shadow[r.addr[addr_w-1:0]]);
            end
            op_wr: begin
               shadow[r.addr[addr_w-1:0]]  = apply_strobes(shadow[r.addr[addr_w-1:0]],
                                                           r.wdata, r.wstrb);
               written[r.addr[addr_w-1:0]] = 1'b1;
               host_access(r.addr, r.wdata, r.wstrb, rd, lat, inv);
            end
            op_crd: begin
               host_access(ctrl_host_addr(r.addr), '0, '0, rd, lat, inv);
               check($sformatf("ctrl reg %0d", r.addr), rd, r.exp);
            end
            op_cwr: begin
               host_access(ctrl_host_addr(r.addr), r.wdata, r.wstrb, rd, lat, inv);
               check("invalidate_out", inv, r.exp);
            end
            op_mem_chk: begin
               @(posedge clk);
               #10;
               do begin
                  @(negedge clk);
                  lat++;
               end while (!wtb_empty_out && lat < drain_timeout);
               if (!wtb_empty_out) begin
                  errors++;
                  $display("Timeout: write-through buffer never drained");
               end else begin
                  for (int a = 0; a < 2**addr_w; a++) begin
                     if (written[a]) check($sformatf("mem[%h]", a), mem[a], shadow[a]);
                  end
               end
               lat = 0;
            end
            op_empty_chain: begin
               @(posedge clk);
               #10;
               wtb_empty_in = 1'b0;    // Downstream level not empty
               @(negedge clk);
               check("wtb_empty_out", wtb_empty_out, 1'b0);
               @(posedge clk);
               #10;
               wtb_empty_in = 1'b1;
            end
            op_inv_in: begin
               @(posedge clk);
               #10;
               invalidate_in = 1'b1;
               @(negedge clk);
               check("invalidate_out", invalidate_out, 1'b1);
               @(posedge clk);
               #10;
               invalidate_in = 1'b0;
            end
            op_slow: slow = r.wdata[0];
            default: ;
         endcase
         if (r.one) check($sformatf("ack latency row %0d", i), lat, 1);
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
